/* source/csb_fifo_pkg.sv */
package csb_fifo_pkg;

    // ==================================================
    // sizes
    // ==================================================

    // one command word toward the register bus master
    localparam int DATA_W = 50;
    // flop ram entries
    localparam int DEPTH  = 4;
    localparam int ADR_W  = 2;
    // must hold DEPTH itself, hence one extra bit
    localparam int CNT_W  = 3;
    // event counters, power of two
    localparam int GRAY_W = 3;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADR_W-1:0]  adr_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [GRAY_W-1:0] gray_t;

    // ==================================================
    // gray increment
    // ==================================================

    // polarity is the xor of all bits
    // even polarity flips the lsb
    // odd polarity flips the bit left of the rightmost one,
    // or the msb when that one is already the msb
    function automatic gray_t gray_inc(input gray_t g);
        gray_t nxt;
        logic  found;
        nxt   = g;
        found = 1'b0;
        if (^g == 1'b0) begin
            nxt[0] = ~g[0];
        end else begin
            // scan up from the lsb for the first one
            for (int i = 0; i < GRAY_W - 1; i++) begin
                if (!found && g[i]) begin
                    nxt[i+1] = ~g[i+1];
                    found    = 1'b1;
                end
            end
            // only the msb was set
            if (!found) begin
                nxt[GRAY_W-1] = ~g[GRAY_W-1];
            end
        end
        return nxt;
    endfunction

endpackage

/* source/csb_fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module csb_fifo_wr_ctrl import csb_fifo_pkg::*; (
    input  logic rd_clk_rd_mgated,
    input  logic wr_reset_,
    input  logic wr_req,
    input  logic wr_popping,
    output logic wr_ready,
    output logic ram_iwe,
    output logic wr_pushing,
    output adr_t wr_adr
);

    // staged request, one cycle behind the accept edge
    logic wr_req_in;
    // input side holding, drives back-pressure
    logic wr_busy_in;
    // internal copy of busy, used for reservation
    logic wr_busy_int;
    logic wr_busy_next;
    logic wr_busy_in_next;
    logic wr_busy_in_int;
    logic wr_reserving;
    // words reserved but not yet seen popped
    cnt_t wr_count;
    cnt_t wr_count_next;

    // ==================================================
    // input staging
    // ==================================================

    assign wr_ready = !wr_busy_in;
    // write data register in the ram loads on the accept edge
    assign ram_iwe  = wr_req && !wr_busy_in;

    // staged request blocked by a full fifo
    assign wr_busy_in_int = wr_req_in && wr_busy_int;

    // new request: follow the fifo busy flag
    // no request: keep holding only while the staged word is stuck
    assign wr_busy_in_next = wr_req ? wr_busy_next
                                    : (wr_req_in && wr_busy_next && !wr_reserving);

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_req_in  <= 1'b0;
            wr_busy_in <= 1'b0;
        end else begin
            wr_busy_in <= wr_busy_in_next;
            // stalled reservation keeps its staged request
            if (!wr_busy_in_int) begin
                wr_req_in <= wr_req && !wr_busy_in;
            end
        end
    end

    // ==================================================
    // occupancy count
    // ==================================================

    assign wr_reserving = wr_req_in && !wr_busy_int;
    // data goes into the ram in the same cycle as the reservation
    assign wr_pushing   = wr_reserving;

    // up on reserve, down on pop, unchanged on both
    always_comb begin
        wr_count_next = wr_count;
        if (wr_reserving && !wr_popping) begin
            wr_count_next = wr_count + cnt_t'(1);
        end else if (!wr_reserving && wr_popping) begin
            wr_count_next = wr_count - cnt_t'(1);
        end
    end

    assign wr_busy_next = (wr_count_next == cnt_t'(DEPTH));

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_busy_int <= 1'b0;
            wr_count    <= '0;
            wr_adr      <= '0;
        end else begin
            wr_busy_int <= wr_busy_next;
            wr_count    <= wr_count_next;
            // ram write address, wraps with the depth
            if (wr_pushing) begin
                wr_adr <= wr_adr + adr_t'(1);
            end
        end
    end

    // pops reach this side late, so the count must never overshoot
    a_wr_count_max: assert property (
        @(posedge rd_clk_rd_mgated) disable iff (!wr_reset_)
        wr_count <= cnt_t'(DEPTH)
    );

endmodule

/* source/csb_fifo_flopram.sv */
`timescale 1ns/1ps

module csb_fifo_flopram import csb_fifo_pkg::*; (
    input  logic  rd_clk_rd_mgated,
    input  data_t di,
    input  logic  iwe,
    input  logic  we,
    input  adr_t  wa,
    input  adr_t  ra,
    output data_t dout
);

    // write data register, loaded on the accept edge
    data_t di_d;
    // entry registers
    data_t ram_ff [DEPTH];

    // ==================================================
    // write port
    // ==================================================

    always_ff @(posedge rd_clk_rd_mgated) begin
        if (iwe) begin
            di_d <= di;
        end
    end

    // entry written one cycle after the data register loads
    always_ff @(posedge rd_clk_rd_mgated) begin
        if (we) begin
            ram_ff[wa] <= di_d;
        end
    end

    // ==================================================
    // read port
    // ==================================================

    // combinational read, registered in the read side
    always_comb begin
        dout = ram_ff[ra];
    end

endmodule

/* source/csb_fifo_event_sync.sv */
`timescale 1ns/1ps

module csb_fifo_event_sync import csb_fifo_pkg::*; (
    input  logic rd_clk_rd_mgated,
    input  logic wr_reset_,
    input  logic src_event,
    output logic dst_event
);

    // sender gray counter, one step per input pulse
    gray_t src_gray;
    // two synchronizer stages
    gray_t sync_q1;
    gray_t sync_q2;
    // receiver copy, trails the synchronized value
    gray_t dst_gray;

    // ==================================================
    // sender
    // ==================================================

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            src_gray <= '0;
        end else if (src_event) begin
            src_gray <= gray_inc(src_gray);
        end
    end

    // ==================================================
    // synchronizer and receiver
    // ==================================================

    // only one bit changes per step, so a sampled value is
    // always an old or a new count, never a mix
    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            dst_gray <= '0;
        end else begin
            sync_q1 <= src_gray;
            sync_q2 <= sync_q1;
            // one step per cycle, one output pulse per step
            if (dst_event) begin
                dst_gray <= gray_inc(dst_gray);
            end
        end
    end

    assign dst_event = (sync_q2 != dst_gray);

    // sender moves only in the cycle after a pulse, one bit per step
    a_src_gray_step: assert property (
        @(posedge rd_clk_rd_mgated) disable iff (!wr_reset_)
        $countones(src_gray ^ $past(src_gray)) == ($past(src_event) ? 1 : 0)
    );

endmodule

/* source/csb_fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module csb_fifo_rd_ctrl import csb_fifo_pkg::*; (
    input  logic  rd_clk_rd_mgated,
    input  logic  wr_reset_,
    input  logic  rd_pushing,
    input  logic  rd_ready,
    input  data_t ram_dout,
    output logic  rd_popping,
    output adr_t  rd_adr,
    output logic  rd_req,
    output data_t rd_data
);

    // words in the ram as seen from this side
    cnt_t rd_count;
    cnt_t rd_count_next;
    // a word can be taken from the ram this cycle
    logic rd_avail;

    // ==================================================
    // count and pop
    // ==================================================

    // a push seen this cycle is already in the ram
    assign rd_avail   = (rd_count != '0) || rd_pushing;
    // output register empty, or its word leaving now
    assign rd_popping = rd_avail && !(rd_req && !rd_ready);

    always_comb begin
        rd_count_next = rd_count;
        if (rd_pushing && !rd_popping) begin
            rd_count_next = rd_count + cnt_t'(1);
        end else if (!rd_pushing && rd_popping) begin
            rd_count_next = rd_count - cnt_t'(1);
        end
    end

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_count <= '0;
            rd_adr   <= '0;
            rd_req   <= 1'b0;
        end else begin
            rd_count <= rd_count_next;
            if (rd_popping) begin
                rd_adr <= rd_adr + adr_t'(1);
            end
            // new word loaded, or old word still waiting
            rd_req <= rd_avail || (rd_req && !rd_ready);
        end
    end

    // ==================================================
    // output data register
    // ==================================================

    always_ff @(posedge rd_clk_rd_mgated) begin
        if (rd_popping) begin
            rd_data <= ram_dout;
        end
    end

    // held word must not move under a stalled consumer
    a_rd_hold: assert property (
        @(posedge rd_clk_rd_mgated) disable iff (!wr_reset_)
        (rd_req && !rd_ready) |=> (rd_req && $stable(rd_data))
    );

    // a pop with no data would wrap the count above DEPTH
    a_rd_count_range: assert property (
        @(posedge rd_clk_rd_mgated) disable iff (!wr_reset_)
        rd_count <= cnt_t'(DEPTH)
    );

endmodule

/* source/csb_fifo.sv */
`timescale 1ns/1ps

module csb_fifo import csb_fifo_pkg::*; (
    input  logic  rd_clk_rd_mgated,
    input  logic  wr_reset_,
    input  logic  wr_req,
    input  data_t wr_data,
    output logic  wr_ready,
    output logic  rd_req,
    input  logic  rd_ready,
    output data_t rd_data
);

    // write side
    logic  wr_pushing;
    logic  wr_popping;
    logic  ram_iwe;
    adr_t  wr_adr;
    // read side
    logic  rd_pushing;
    logic  rd_popping;
    adr_t  rd_adr;
    data_t ram_dout;

    // ==================================================
    // write side and ram
    // ==================================================

    csb_fifo_wr_ctrl wr_ctrl (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_req           (wr_req),
        .wr_popping       (wr_popping),
        .wr_ready         (wr_ready),
        .ram_iwe          (ram_iwe),
        .wr_pushing       (wr_pushing),
        .wr_adr           (wr_adr)
    );

    // entry write enable is the push pulse itself
    csb_fifo_flopram ram (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .di               (wr_data),
        .iwe              (ram_iwe),
        .we               (wr_pushing),
        .wa               (wr_adr),
        .ra               (rd_adr),
        .dout             (ram_dout)
    );

    // ==================================================
    // event crossings
    // ==================================================

    // pushes toward the read side
    csb_fifo_event_sync push_sync (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .src_event        (wr_pushing),
        .dst_event        (rd_pushing)
    );

    // pops back to the write side
    csb_fifo_event_sync pop_sync (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .src_event        (rd_popping),
        .dst_event        (wr_popping)
    );

    // ==================================================
    // read side
    // ==================================================

    csb_fifo_rd_ctrl rd_ctrl (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .rd_pushing       (rd_pushing),
        .rd_ready         (rd_ready),
        .ram_dout         (ram_dout),
        .rd_popping       (rd_popping),
        .rd_adr           (rd_adr),
        .rd_req           (rd_req),
        .rd_data          (rd_data)
    );

endmodule

/* testbench/csb_fifo_checks.svh */
`ifndef CSB_FIFO_CHECKS_SVH
`define CSB_FIFO_CHECKS_SVH

// ==================================================
// compare tasks
// ==================================================

// one command word
task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
        $display("Simulation failed");
        $fatal(1, "data compare failed");
    end
endtask

// handshake flags
task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s, expected %b, got %b", $time, what, exp, got);
        $display("Simulation failed");
        $fatal(1, "flag compare failed");
    end
endtask

// word counts
task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("Mismatch at %0t: %s, expected %0d, got %0d", $time, what, exp, got);
        $display("Simulation failed");
        $fatal(1, "count compare failed");
    end
endtask

// a wait ran past its limit
task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "wait timed out");
endtask

// ==================================================
// random numbers
// ==================================================

// 32 bit lcg, full period constants
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`endif

/* testbench/csb_fifo_tb.sv */
`timescale 1ns/1ps

module csb_fifo_tb import csb_fifo_pkg::*; ();

    // ==================================================
    // table layout and limits
    // ==================================================

    localparam int NUM_STEPS = 24;
    // rows from here hold the stall test words
    localparam int FILL_ROW  = 1;
    // output register, DEPTH ram entries and the staged write word
    localparam int STALL_CAP = DEPTH + 2;
    localparam int RAND_ROW  = FILL_ROW + STALL_CAP;
    // cycles any one wait may take
    localparam int TIMEOUT   = 200;

    logic  rd_clk_rd_mgated;
    logic  wr_reset_;
    logic  wr_req;
    data_t wr_data;
    logic  wr_ready;
    logic  rd_req;
    logic  rd_ready;
    data_t rd_data;

    // per step: word, idle cycles before the write, read stall cycles
    data_t       step_data  [NUM_STEPS];
    int          step_idle  [NUM_STEPS];
    int          step_stall [NUM_STEPS];
    // accepted words, oldest first
    data_t       expect_q   [$];
    logic [31:0] lcg_state;
    int          waited;
    int          fill_n;
    int          low_n;
    logic        taken;

    `include "csb_fifo_checks.svh"

    csb_fifo uut (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_req           (wr_req),
        .wr_data          (wr_data),
        .wr_ready         (wr_ready),
        .rd_req           (rd_req),
        .rd_ready         (rd_ready),
        .rd_data          (rd_data)
    );

    // 20 ns clock
    initial begin
        rd_clk_rd_mgated = 1'b0;
        forever #10 rd_clk_rd_mgated = ~rd_clk_rd_mgated;
    end

    // ==================================================
    // helpers
    // ==================================================

    task automatic build_table();
        logic [31:0] hi;
        logic [31:0] lo;
        // single write, held three cycles at the output
        step_data[0]  = 50'h3_1234_5678_9abc;
        step_idle[0]  = 0;
        step_stall[0] = 3;
        for (int i = 1; i < NUM_STEPS; i++) begin
            hi = lcg_next();
            lo = lcg_next();
            if (i < RAND_ROW) begin
                // fill words, row number in the low bits
                step_data[i]  = {18'h2_c0de, 32'(i)};
                step_idle[i]  = 0;
                step_stall[i] = 2;
            end else begin
                step_data[i]  = {hi[DATA_W-33:0], lo};
                step_idle[i]  = int'(lcg_next() % 32'd4);
                step_stall[i] = int'(lcg_next() % 32'd8);
            end
        end
    endtask

    // head of the queue against the output register
    task automatic verify_head(input string what);
        if (expect_q.size() == 0) begin
            $display("Error at %0t: rd_req is high with no word outstanding", $time);
            $display("Simulation failed");
            $fatal(1, "unexpected read word");
        end else begin
            check_data(rd_data, expect_q[0], what);
        end
    endtask

    // wr_ready only moves on the rising edge, so the negedge value decides
    task automatic write_word(input data_t w);
        int wait_n;
        wait_n  = 0;
        wr_req  = 1'b1;
        wr_data = w;
        while (!wr_ready) begin
            @(negedge rd_clk_rd_mgated);
            wait_n++;
            if (wait_n > TIMEOUT) begin
                report_timeout("wr_ready never returned for a pending write");
            end
        end
        @(negedge rd_clk_rd_mgated);
        expect_q.push_back(w);
        wr_req = 1'b0;
    endtask

    // stall the consumer, then take the head word
    task automatic read_word(input int stall);
        int wait_n;
        rd_ready = 1'b0;
        // held word must stay put
        repeat (stall) begin
            @(negedge rd_clk_rd_mgated);
            if (rd_req) begin
                verify_head("rd_data during a read stall");
            end
        end
        rd_ready = 1'b1;
        wait_n   = 0;
        while (!rd_req) begin
            @(negedge rd_clk_rd_mgated);
            wait_n++;
            if (wait_n > TIMEOUT) begin
                report_timeout("rd_req never rose for an outstanding read");
            end
        end
        // both high, word leaves at the next edge
        verify_head("rd_data at the read handshake");
        void'(expect_q.pop_front());
        @(negedge rd_clk_rd_mgated);
        rd_ready = 1'b0;
    endtask

    // ==================================================
    // test sequence
    // ==================================================

    initial begin
        wr_reset_ = 1'b0;
        wr_req    = 1'b0;
        wr_data   = '0;
        rd_ready  = 1'b0;
        lcg_state = 32'h91c5;
        build_table();
        repeat (2) @(negedge rd_clk_rd_mgated);
        wr_reset_ = 1'b1;
        @(negedge rd_clk_rd_mgated);
        check_flag(wr_ready, 1'b1, "wr_ready after reset");
        check_flag(rd_req, 1'b0, "rd_req after reset");

        // single word through an idle fifo
        write_word(step_data[0]);
        waited = 0;
        while (!rd_req) begin
            @(negedge rd_clk_rd_mgated);
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("single word never reached rd_req");
            end
        end
        read_word(step_stall[0]);

        // fill under a read stall until wr_ready stays low 10 cycles
        fill_n  = 0;
        low_n   = 0;
        waited  = 0;
        wr_req  = 1'b1;
        wr_data = step_data[FILL_ROW];
        while (low_n < 10 && fill_n <= STALL_CAP) begin
            taken = wr_ready;
            @(negedge rd_clk_rd_mgated);
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("wr_ready kept toggling under a read stall");
            end
            if (taken) begin
                expect_q.push_back(wr_data);
                fill_n++;
                low_n   = 0;
                wr_data = step_data[FILL_ROW + fill_n];
            end else begin
                low_n++;
            end
        end
        wr_req = 1'b0;
        check_count(fill_n, STALL_CAP, "words accepted under a read stall");
        for (int i = 0; i < STALL_CAP; i++) begin
            read_word(step_stall[FILL_ROW + i]);
        end

        // random gaps on both sides, writer and reader in parallel
        fork
            begin
                for (int i = RAND_ROW; i < NUM_STEPS; i++) begin
                    repeat (step_idle[i]) @(negedge rd_clk_rd_mgated);
                    write_word(step_data[i]);
                end
            end
            begin
                for (int j = RAND_ROW; j < NUM_STEPS; j++) begin
                    read_word(step_stall[j]);
                end
            end
        join

        // drained fifo goes back to idle
        waited = 0;
        while (rd_req || !wr_ready) begin
            @(negedge rd_clk_rd_mgated);
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("fifo did not return to idle after the last read");
            end
        end
        // no stray word may follow the last read
        repeat (10) begin
            @(negedge rd_clk_rd_mgated);
            check_flag(rd_req, 1'b0, "rd_req after the fifo drained");
            check_flag(wr_ready, 1'b1, "wr_ready after the fifo drained");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+testbench
source/csb_fifo_pkg.sv
source/csb_fifo_wr_ctrl.sv
source/csb_fifo_flopram.sv
source/csb_fifo_event_sync.sv
source/csb_fifo_rd_ctrl.sv
source/csb_fifo.sv
testbench/csb_fifo_tb.sv

/* Makefile */
# verilator build and run of the command fifo testbench

SIM = obj_dir/csb_fifo_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module csb_fifo_tb -o csb_fifo_sim
	./$(SIM)

clean:
	rm -rf obj_dir
